// ==== common/keypad_pkg.sv ====
package keypad_pkg;

	typedef logic [3:0]  matrix_t;       // row or column lines, active low
	typedef logic [3:0]  key_code_t;     // 0 to F
	typedef logic [3:0]  fifo_level_t;   // 0 to 8 entries
	typedef logic [3:0]  debounce_cnt_t;
	typedef logic [7:0]  apb_addr_t;
	typedef logic [31:0] apb_data_t;

	typedef enum logic [1:0] {
		idle_debounce,
		scanning,
		release_debounce
	} scan_state_t;

	typedef struct packed {
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
	} apb_req_t;

	typedef struct packed {
		apb_data_t prdata;
		logic      pready;
		logic      pslverr;
	} apb_rsp_t;

	localparam int DEBOUNCE_MS = 10;      // stable 1 ms cycles for press or release
	localparam int FIFO_DEPTH  = 8;
	localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);

	typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;

	localparam matrix_t MATRIX_OPEN    = 4'b1111;   // no key closing a line
	localparam matrix_t SCAN_FIRST_COL = 4'b1110;   // scan starts at column 0

	localparam apb_addr_t ADDR_STATUS = 8'h00;
	localparam apb_addr_t ADDR_DATA   = 8'h04;
	localparam apb_addr_t ADDR_CTRL   = 8'h08;

	localparam int STAT_LEVEL_LSB = 0;   // bits 3:0
	localparam int STAT_EMPTY_BIT = 4;
	localparam int STAT_OVF_BIT   = 5;

	localparam int DATA_CODE_LSB  = 0;   // bits 3:0
	localparam int DATA_VALID_BIT = 8;

	localparam int CTRL_SCAN_EN_BIT = 0;
	localparam int CTRL_IRQ_EN_BIT  = 1;
	localparam int CTRL_OVF_CLR_BIT = 2;   // write one, self clearing

endpackage

// ==== hw/keypad_scan/keypad_scanner.sv ====
`timescale 1ns/100ps

module keypad_scanner import keypad_pkg::*; (
	input  logic      clk_1khz,
	input  logic      sys_rst_n,
	input  logic      scan_en,
	input  matrix_t   row,
	output matrix_t   col,
	output logic      key_push,
	output key_code_t key_code
);

	localparam debounce_cnt_t DEB_LAST = debounce_cnt_t'(DEBOUNCE_MS - 1);

	scan_state_t   state;
	debounce_cnt_t deb_cnt;   // shared by press and release
	matrix_t       row_hit;   // row lines seen at detection
	matrix_t       col_hit;   // column drive at detection
	logic          row_active;

	// position of the lowest zero, so the lowest row wins
	function automatic logic [1:0] low_index(input matrix_t lines);
		logic [1:0] idx;
		idx = 2'd0;
		for (int i = 3; i >= 0; i--) begin
			if (!lines[i])
				idx = 2'(i);
		end
		return idx;
	endfunction

	assign row_active = (row != MATRIX_OPEN);

	always_ff @(posedge clk_1khz or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= idle_debounce;
			deb_cnt  <= '0;
			col      <= '0;
			key_push <= 1'b0;
		end else if (!scan_en) begin
			state    <= idle_debounce;   // parked, columns released
			deb_cnt  <= '0;
			col      <= MATRIX_OPEN;
			key_push <= 1'b0;
		end else begin
			key_push <= 1'b0;
			case (state)
				idle_debounce: begin
					col <= '0;   // all columns low, any key pulls a row
					if (!row_active) begin
						deb_cnt <= '0;   // bounce restarts the count
					end else if (deb_cnt == DEB_LAST) begin
						deb_cnt <= '0;
						col     <= SCAN_FIRST_COL;
						state   <= scanning;
					end else begin
						deb_cnt <= deb_cnt + 1'b1;
					end
				end
				scanning: begin
					if (!row_active) begin
						col <= {col[2:0], col[3]};   // walk the zero left
					end else begin
						key_push <= 1'b1;
						col      <= '0;
						state    <= release_debounce;
					end
				end
				release_debounce: begin
					if (row_active) begin
						deb_cnt <= '0;   // still held or bouncing
					end else if (deb_cnt == DEB_LAST) begin
						deb_cnt <= '0;
						state   <= idle_debounce;
					end else begin
						deb_cnt <= deb_cnt + 1'b1;
					end
				end
				default: state <= idle_debounce;
			endcase
		end
	end

	// key position, valid together with key_push
	always_ff @(posedge clk_1khz) begin
		if (scan_en && state == scanning && row_active) begin
			row_hit <= row;
			col_hit <= col;
		end
	end

	assign key_code = {low_index(row_hit), low_index(col_hit)};   // row * 4 + col

endmodule

// ==== hw/key_fifo.sv ====
`timescale 1ns/100ps

module key_fifo import keypad_pkg::*; (
	input  logic        clk_1khz,
	input  logic        sys_rst_n,
	input  logic        wr,
	input  key_code_t   wr_data,
	input  logic        rd,
	input  logic        ovf_clr,
	output key_code_t   rd_data,
	output fifo_level_t level,
	output logic        overflow
);

	key_code_t mem [FIFO_DEPTH];
	fifo_ptr_t wr_ptr;
	fifo_ptr_t rd_ptr;
	logic      empty;
	logic      full;
	logic      do_wr;
	logic      do_rd;

	assign empty = (level == '0);
	assign full  = (level == fifo_level_t'(FIFO_DEPTH));
	assign do_wr = wr && !full;    // code lost when full
	assign do_rd = rd && !empty;

	assign rd_data = mem[rd_ptr];   // head of queue, read combinationally

	always_ff @(posedge clk_1khz) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk_1khz or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			level    <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;   // wraps at depth 8
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;   // both or neither
			endcase
			if (wr && full)
				overflow <= 1'b1;   // sticky until cleared
			else if (ovf_clr)
				overflow <= 1'b0;
		end
	end

endmodule

// ==== hw/apb_key_regs.sv ====
`timescale 1ns/100ps

module apb_key_regs import keypad_pkg::*; (
	input  logic        clk_1khz,
	input  logic        sys_rst_n,
	input  apb_req_t    apb_req,
	output apb_rsp_t    apb_rsp,
	input  fifo_level_t level,
	input  logic        overflow,
	input  key_code_t   rd_data,
	output logic        rd,
	output logic        scan_en,
	output logic        ovf_clr,
	output logic        irq
);

	logic      access;
	logic      sel_status;
	logic      sel_data;
	logic      sel_ctrl;
	logic      ctrl_wr;
	logic      irq_en;
	logic      fifo_has_data;
	apb_data_t status_word;
	apb_data_t data_word;
	apb_data_t ctrl_word;

	assign access     = apb_req.psel && apb_req.penable;   // access phase
	assign sel_status = (apb_req.paddr == ADDR_STATUS);
	assign sel_data   = (apb_req.paddr == ADDR_DATA);
	assign sel_ctrl   = (apb_req.paddr == ADDR_CTRL);
	assign ctrl_wr    = access && apb_req.pwrite && sel_ctrl;

	assign fifo_has_data = (level != '0);

	// pop only on a completed DATA read with something queued
	assign rd      = access && !apb_req.pwrite && sel_data && fifo_has_data;
	assign ovf_clr = ctrl_wr && apb_req.pwdata[CTRL_OVF_CLR_BIT];
	assign irq     = irq_en && fifo_has_data;

	always_ff @(posedge clk_1khz or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			scan_en <= 1'b0;
			irq_en  <= 1'b0;
		end else if (ctrl_wr) begin
			scan_en <= apb_req.pwdata[CTRL_SCAN_EN_BIT];
			irq_en  <= apb_req.pwdata[CTRL_IRQ_EN_BIT];
		end
	end

	always_comb begin
		status_word = '0;
		status_word[STAT_LEVEL_LSB +: $bits(fifo_level_t)] = level;
		status_word[STAT_EMPTY_BIT] = !fifo_has_data;
		status_word[STAT_OVF_BIT]   = overflow;

		data_word = '0;
		if (fifo_has_data)
			data_word[DATA_CODE_LSB +: $bits(key_code_t)] = rd_data;
		data_word[DATA_VALID_BIT] = fifo_has_data;

		ctrl_word = '0;   // ovf_clr always reads 0
		ctrl_word[CTRL_SCAN_EN_BIT] = scan_en;
		ctrl_word[CTRL_IRQ_EN_BIT]  = irq_en;
	end

	always_comb begin
		apb_rsp.pready  = 1'b1;   // no wait states
		apb_rsp.pslverr = access && !(sel_status || sel_data || sel_ctrl);
		if (sel_status)
			apb_rsp.prdata = status_word;
		else if (sel_data)
			apb_rsp.prdata = data_word;
		else if (sel_ctrl)
			apb_rsp.prdata = ctrl_word;
		else
			apb_rsp.prdata = '0;
	end

endmodule

// ==== hw/keypad_ctrl_top.sv ====
`timescale 1ns/100ps

module keypad_ctrl_top import keypad_pkg::*; (
	input  logic     clk_1khz,
	input  logic     sys_rst_n,
	input  matrix_t  row,
	output matrix_t  col,
	input  apb_req_t apb_req,
	output apb_rsp_t apb_rsp,
	output logic     irq
);

	logic        key_push;
	key_code_t   key_code;
	logic        rd;
	logic        scan_en;
	logic        ovf_clr;
	key_code_t   rd_data;
	fifo_level_t level;
	logic        overflow;

	keypad_scanner keypad_scanner_i (
		.clk_1khz  (clk_1khz),
		.sys_rst_n (sys_rst_n),
		.scan_en   (scan_en),
		.row       (row),
		.col       (col),
		.key_push  (key_push),
		.key_code  (key_code)
	);

	key_fifo key_fifo_i (
		.clk_1khz  (clk_1khz),
		.sys_rst_n (sys_rst_n),
		.wr        (key_push),   // one code per detected press
		.wr_data   (key_code),
		.rd        (rd),
		.ovf_clr   (ovf_clr),
		.rd_data   (rd_data),
		.level     (level),
		.overflow  (overflow)
	);

	apb_key_regs apb_key_regs_i (
		.clk_1khz  (clk_1khz),
		.sys_rst_n (sys_rst_n),
		.apb_req   (apb_req),
		.apb_rsp   (apb_rsp),
		.level     (level),
		.overflow  (overflow),
		.rd_data   (rd_data),
		.rd        (rd),
		.scan_en   (scan_en),
		.ovf_clr   (ovf_clr),
		.irq       (irq)
	);

endmodule

// ==== bench/keypad_model.sv ====
`timescale 1ns/100ps

module keypad_model import keypad_pkg::*; (
	input  matrix_t   col,
	input  key_code_t key,       // row in bits 3:2, column in bits 1:0
	input  logic      pressed,
	input  logic      bounce,    // contact forced open
	output matrix_t   row
);

	logic closed;

	assign closed = pressed && !bounce;

	// switch closes a row line only while its column is driven low
	always_comb begin
		row = MATRIX_OPEN;
		if (closed && !col[key[1:0]])
			row[key[3:2]] = 1'b0;
	end

endmodule

// ==== bench/tb_keypad_ctrl.sv ====
`timescale 1ns/100ps

module tb_keypad_ctrl import keypad_pkg::*; ();

	localparam int MAX_RECORDS    = 64;
	localparam int RESET_CYCLES   = 10;
	localparam int APB_WAIT_LIMIT = 16;
	localparam int MAX_PULSE      = 16;   // one open and one closed phase of up to 8 cycles

	logic        clk_1khz;
	logic        sys_rst_n;
	matrix_t     row;
	matrix_t     col;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;
	logic        irq;
	key_code_t   key;
	logic        pressed;
	logic        bounce;
	logic [31:0] golden [4*MAX_RECORDS];   // op, key or addr, length or wdata, expected
	logic [16:0] lfsr;
	logic        test_ok;
	int          cycle_cnt = 0;
	int          cycle_limit = 0;
	int          pass_cnt;
	int          fail_cnt;

	always #5 clk_1khz = ~clk_1khz;

	keypad_ctrl_top keypad_ctrl_top_i (
		.clk_1khz  (clk_1khz),
		.sys_rst_n (sys_rst_n),
		.row       (row),
		.col       (col),
		.apb_req   (apb_req),
		.apb_rsp   (apb_rsp),
		.irq       (irq)
	);

	keypad_model keypad_model_i (
		.col     (col),
		.key     (key),
		.pressed (pressed),
		.bounce  (bounce),
		.row     (row)
	);

	// x^17 + x^14 + 1
	function automatic logic [16:0] lfsr_next(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	function automatic logic is_unmapped(input apb_addr_t addr);
		return !(addr == ADDR_STATUS || addr == ADDR_DATA || addr == ADDR_CTRL);
	endfunction

	task automatic draw_width(output int width);
		width = 0;
		for (int i = 0; i < 3; i++) begin
			lfsr = lfsr_next(lfsr);
			width = (width << 1) | int'(lfsr[0]);
		end
		width = width + 1;   // 1 to 8 cycles
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
			test_ok = 1'b0;
		end
	endtask

	task automatic press_key(input key_code_t k, input int hold, input int release_pulses);
		int w;
		@(posedge clk_1khz);
		key     <= k;
		pressed <= 1'b1;
		bounce  <= 1'b0;
		repeat (hold) @(posedge clk_1khz);
		for (int p = 0; p < release_pulses; p++) begin
			draw_width(w);
			bounce <= 1'b1;   // contact lifts
			repeat (w) @(posedge clk_1khz);
			draw_width(w);
			bounce <= 1'b0;   // and touches again
			repeat (w) @(posedge clk_1khz);
		end
		pressed <= 1'b0;
		bounce  <= 1'b0;
		repeat (hold) @(posedge clk_1khz);
	endtask

	task automatic bounce_key(input key_code_t k, input int pulses);
		int w;
		@(posedge clk_1khz);
		key     <= k;
		pressed <= 1'b1;
		for (int p = 0; p < pulses; p++) begin
			draw_width(w);
			bounce <= 1'b0;   // closed for less than the debounce window
			repeat (w) @(posedge clk_1khz);
			draw_width(w);
			bounce <= 1'b1;
			repeat (w) @(posedge clk_1khz);
		end
		pressed <= 1'b0;
		bounce  <= 1'b0;
	endtask

	task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
			output apb_data_t rdata, output logic slverr);
		int waits;
		waits = 0;
		@(posedge clk_1khz);
		apb_req.psel    <= 1'b1;   // setup cycle
		apb_req.penable <= 1'b0;
		apb_req.pwrite  <= write;
		apb_req.paddr   <= addr;
		apb_req.pwdata  <= wdata;
		@(posedge clk_1khz);
		apb_req.penable <= 1'b1;
		@(negedge clk_1khz);
		while (!apb_rsp.pready && waits < APB_WAIT_LIMIT) begin
			@(negedge clk_1khz);
			waits++;
		end
		assert (apb_rsp.pready) else begin
			$display("APB access to address 0x%02h never completed", addr);
			test_ok = 1'b0;
		end
		rdata  = apb_rsp.prdata;   // read in the middle of the access cycle
		slverr = apb_rsp.pslverr;
		@(posedge clk_1khz);
		apb_req <= '0;
	endtask

	always @(posedge clk_1khz) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("timeout after %0d cycles, the golden table did not finish", cycle_cnt);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		int        op;
		int        arg;
		int        val;
		int        expv;
		int        n_rec;
		apb_data_t rdata;
		logic      slverr;
		logic      scan_on;
		clk_1khz  = 1'b0;
		sys_rst_n <= 1'b0;
		apb_req   <= '0;
		key       <= '0;
		pressed   <= 1'b0;
		bounce    <= 1'b0;
		lfsr      = 17'd71543;
		pass_cnt  = 0;
		fail_cnt  = 0;
		scan_on   = 1'b0;   // CTRL is 0 after reset
		for (int i = 0; i < 4*MAX_RECORDS; i++)
			golden[i] = '0;
		$readmemh("bench/keypad_golden.txt", golden);

		n_rec = 0;
		cycle_limit = RESET_CYCLES;
		while (n_rec < MAX_RECORDS && golden[4*n_rec] != 0) begin
			val  = int'(golden[4*n_rec+2]);
			expv = int'(golden[4*n_rec+3]);
			if (golden[4*n_rec] == 1)
				cycle_limit += 2*val + MAX_PULSE*expv;
			else if (golden[4*n_rec] == 2)
				cycle_limit += MAX_PULSE*val;
			cycle_limit += 20;
			n_rec++;
		end
		if (n_rec == 0)
			$display("golden file holds no test records");

		repeat (RESET_CYCLES) @(posedge clk_1khz);
		sys_rst_n <= 1'b1;

		for (int r = 0; r < n_rec; r++) begin
			op      = int'(golden[4*r]);
			arg     = int'(golden[4*r+1]);
			val     = int'(golden[4*r+2]);
			expv    = int'(golden[4*r+3]);
			test_ok = 1'b1;
			case (op)
				1: begin
					press_key(key_code_t'(arg), val, expv);
					@(negedge clk_1khz);
					// idle scanner drives all columns low, a parked one releases them
					check_value("col", 32'(scan_on ? 4'b0000 : 4'b1111), 32'(col));
				end
				2: bounce_key(key_code_t'(arg), val);
				3: begin
					apb_access(1'b1, apb_addr_t'(arg), apb_data_t'(val), rdata, slverr);
					check_value("pslverr", 32'(is_unmapped(apb_addr_t'(arg))), 32'(slverr));
					if (apb_addr_t'(arg) == ADDR_CTRL)
						scan_on = val[CTRL_SCAN_EN_BIT];
				end
				4: begin
					apb_access(1'b0, apb_addr_t'(arg), '0, rdata, slverr);
					if (!is_unmapped(apb_addr_t'(arg)))
						check_value("prdata", golden[4*r+3], rdata);
					check_value("pslverr", 32'(is_unmapped(apb_addr_t'(arg))), 32'(slverr));
				end
				5: begin
					@(negedge clk_1khz);
					check_value("irq", golden[4*r+3], 32'(irq));
				end
				default: begin
					$display("golden record %0d has unknown operation %0d", r, op);
					test_ok = 1'b0;
				end
			endcase
			$display("test %0d op %0d arg 0x%02h: %s", r, op, arg, test_ok ? "ok" : "mismatch");
			if (test_ok)
				pass_cnt++;
			else
				fail_cnt++;
		end

		$display("%0d tests passed, %0d tests with errors", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && n_rec > 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== bench/keypad_golden.txt ====
// op: 1 press, 2 bounce, 3 apb write, 4 apb read, 5 irq check (all hex)
// op  key/addr  hold/pulses/wdata  expected (press: bounce pulses at release)
4 08 0  0      // CTRL after reset
4 00 0  10     // STATUS empty
4 0c 0  0      // unmapped, pslverr
1 5  14 0      // scan still disabled
5 0  0  0
3 08 3  0      // scan_en and irq_en
2 6  6  0      // short contact only
1 6  14 5      // bounce on release
5 0  0  1
4 00 0  1      // exactly one code
4 04 0  106
5 0  0  0
4 00 0  10
1 a  64 0      // held 100 cycles
4 04 0  10a
4 00 0  10
1 0  14 0
1 1  14 0
1 2  14 0
1 3  14 0
1 4  14 0
1 5  14 0
1 6  14 0
1 7  14 0
1 8  14 0      // ninth code is lost
5 0  0  1
4 00 0  28     // level 8 and overflow
3 08 5  0      // ovf_clr, irq_en off
4 08 0  1
5 0  0  0
4 00 0  08
4 04 0  100
4 04 0  101
4 04 0  102
4 04 0  103
4 04 0  104
4 04 0  105
4 04 0  106
4 04 0  107
4 04 0  0      // drained, valid 0
1 8  14 0
1 9  14 0
1 a  14 0
1 b  14 0
1 c  14 0
1 d  14 0
1 e  14 0
1 f  14 0
4 04 0  108
4 04 0  109
4 04 0  10a
4 04 0  10b
4 04 0  10c
4 04 0  10d
4 04 0  10e
4 04 0  10f
4 00 0  10

// ==== build.f ====
common/keypad_pkg.sv
hw/keypad_scan/keypad_scanner.sv
hw/key_fifo.sv
hw/apb_key_regs.sv
hw/keypad_ctrl_top.sv
bench/keypad_model.sv
bench/tb_keypad_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_keypad_ctrl
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
